// File: hdl/dphy_rx_config.svh
`ifndef DPHY_RX_CONFIG_SVH
`define DPHY_RX_CONFIG_SVH

// Number of HS data lanes
// Must divide 4 so that lane words fill a 32-bit output word
`define DPHY_DATA_LANES 2

// Byte clocks ignored after a lane enters LP-00
`define DPHY_SETTLE_CYCLES 6

// HS leader sequence sent ahead of every packet
`define DPHY_SYNC_BYTE 8'hB8

// Per-lane deskew FIFO depth
// The largest lane skew absorbed is one less than this
`define DPHY_DESKEW_DEPTH 4

`endif

// File: hdl/dphy_rx_pkg.sv
`include "dphy_rx_config.svh"

package dphy_rx_pkg;

  // One byte of HS lane data
  typedef logic [7:0] lane_byte_t;

  // One byte per lane, lane 0 in the low byte
  typedef lane_byte_t [`DPHY_DATA_LANES-1:0] lane_bytes_t;

  // One flag per lane
  typedef logic [`DPHY_DATA_LANES-1:0] lane_mask_t;

endpackage

// File: hdl/dphy_lane_if.sv
interface dphy_lane_if;
  import dphy_rx_pkg::*;

  // Unaligned byte from the front end and its settle qualifier
  lane_byte_t raw_byte;
  logic       hs_valid;

  // Realigned byte from the sync hunter
  lane_byte_t aligned_byte;
  logic       aligned_valid;

  modport front (
    output raw_byte,
    output hs_valid
  );

  modport align (
    input  raw_byte,
    input  hs_valid,
    output aligned_byte,
    output aligned_valid
  );

  // Deskew side only looks at aligned data
  modport deskew (
    input  aligned_byte,
    input  aligned_valid
  );

endinterface

// File: hdl/dphy_rx_front.sv
`include "dphy_rx_config.svh"

module dphy_rx_front (
  input  logic                     byte_clk,
  input  logic                     rst_n_i,
  input  dphy_rx_pkg::lane_bytes_t lane_byte_i,
  input  dphy_rx_pkg::lane_mask_t  lp_p_i,
  input  dphy_rx_pkg::lane_mask_t  lp_n_i,
  dphy_lane_if.front               lane_o [`DPHY_DATA_LANES],
  output logic                     eop_o
);
  import dphy_rx_pkg::*;

  localparam int LANES  = `DPHY_DATA_LANES;
  localparam int SETTLE = `DPHY_SETTLE_CYCLES;
  localparam int SET_W  = $clog2(SETTLE + 1);

  lane_mask_t lp_p_q;
  lane_mask_t lp_n_q;
  lane_mask_t in_hs;
  logic       any_hs_q;

  // LP lines idle at LP-11 out of reset
  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
    begin
      lp_p_q <= '1;
      lp_n_q <= '1;
    end
    else
    begin
      lp_p_q <= lp_p_i;
      lp_n_q <= lp_n_i;
    end
  end

  // Lane is in HS while both LP lines read low
  assign in_hs = ~lp_p_q & ~lp_n_q;

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    logic [SET_W-1:0] settle_cnt;

    always_ff @(posedge byte_clk)
    begin
      lane_o[i].raw_byte <= lane_byte_i[i];
    end

    // Saturating count of cycles spent in LP-00
    always_ff @(posedge byte_clk)
    begin
      if (!rst_n_i)
        settle_cnt <= '0;
      else if (!in_hs[i])
        settle_cnt <= '0;
      else if (settle_cnt != SET_W'(SETTLE))
        settle_cnt <= settle_cnt + 1'b1;
    end

    // Bytes during the settle window are hidden
    assign lane_o[i].hs_valid = in_hs[i] && (settle_cnt == SET_W'(SETTLE));
  end

  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
      any_hs_q <= 1'b0;
    else
      any_hs_q <= |in_hs;
  end

  // End of packet once the last lane has dropped out of HS
  assign eop_o = any_hs_q && !(|in_hs);

endmodule

// File: hdl/dphy_byte_align.sv
`include "dphy_rx_config.svh"

module dphy_byte_align (
  input  logic       byte_clk,
  input  logic       rst_n_i,
  input  logic       reset_align_i,
  dphy_lane_if.align lane_io
);
  import dphy_rx_pkg::*;

  lane_byte_t  prev_byte;
  logic        prev_hs;
  logic [15:0] window_q;
  logic        window_vld;
  logic        locked;
  logic [2:0]  offset;
  logic        sync_hit;
  logic [2:0]  sync_offset;

  // Bits arrive LSB first so the newer byte sits on top
  always_ff @(posedge byte_clk)
  begin
    prev_byte <= lane_io.raw_byte;
    window_q  <= {lane_io.raw_byte, prev_byte};
  end

  // Window only counts when both of its bytes are past settle
  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
    begin
      prev_hs    <= 1'b0;
      window_vld <= 1'b0;
    end
    else
    begin
      prev_hs    <= lane_io.hs_valid;
      window_vld <= lane_io.hs_valid && prev_hs;
    end
  end

  // Lowest matching offset is the earliest leader in time
  always_comb
  begin
    sync_hit    = 1'b0;
    sync_offset = 3'd0;
    for (int s = 7; s >= 0; s--)
    begin
      if (window_q[s +: 8] == `DPHY_SYNC_BYTE)
      begin
        sync_hit    = 1'b1;
        sync_offset = 3'(s);
      end
    end
  end

  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
    begin
      locked                <= 1'b0;
      offset                <= 3'd0;
      lane_io.aligned_valid <= 1'b0;
    end
    else if (reset_align_i || !window_vld)
    begin
      locked                <= 1'b0;
      lane_io.aligned_valid <= 1'b0;
    end
    else if (!locked)
    begin
      // The leader itself is swallowed here
      locked                <= sync_hit;
      offset                <= sync_offset;
      lane_io.aligned_valid <= 1'b0;
    end
    else
      lane_io.aligned_valid <= 1'b1;
  end

  always_ff @(posedge byte_clk)
  begin
    lane_io.aligned_byte <= window_q[offset +: 8];
  end

endmodule

// File: hdl/dphy_word_align.sv
`include "dphy_rx_config.svh"

module dphy_word_align (
  input  logic                     byte_clk,
  input  logic                     rst_n_i,
  input  logic                     eop_i,
  dphy_lane_if.deskew              lanes_i [`DPHY_DATA_LANES],
  output dphy_rx_pkg::lane_bytes_t word_o,
  output logic                     word_valid_o,
  output logic                     reset_align_o
);
  import dphy_rx_pkg::*;

  localparam int LANES = `DPHY_DATA_LANES;
  localparam int DEPTH = `DPHY_DESKEW_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  // Aligner latency plus the FIFO cycle behind the last HS byte
  localparam int DRAIN = 3;

  lane_mask_t       push;
  lane_mask_t       not_empty;
  lane_bytes_t      head;
  logic             pop;
  logic             skew_wait;
  logic             flush;
  logic [CNT_W-1:0] wait_cnt;
  logic [DRAIN-1:0] eop_q;

  // Release only when every lane has a byte waiting
  assign pop       = &not_empty;
  assign skew_wait = |not_empty && !pop;

  // One lane held data for DEPTH cycles and another never showed up
  assign reset_align_o = skew_wait && (wait_cnt == CNT_W'(DEPTH - 1));
  assign flush         = eop_q[DRAIN-1] || reset_align_o;

  for (genvar i = 0; i < LANES; i++)
  begin : g_fifo
    lane_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign push[i]      = lanes_i[i].aligned_valid;
    assign not_empty[i] = (count != '0);
    assign head[i]      = mem[rd_ptr];

    always_ff @(posedge byte_clk)
    begin
      if (push[i] && !flush)
        mem[wr_ptr] <= lanes_i[i].aligned_byte;
    end

    always_ff @(posedge byte_clk)
    begin
      if (!rst_n_i || flush)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end
      else
      begin
        if (push[i])
          wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (pop)
          rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count <= count + CNT_W'(push[i]) - CNT_W'(pop);
      end
    end
  end

  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
    begin
      wait_cnt <= '0;
      eop_q    <= '0;
    end
    else
    begin
      eop_q <= {eop_q[DRAIN-2:0], eop_i};
      if (flush || !skew_wait)
        wait_cnt <= '0;
      else
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge byte_clk)
  begin
    word_o <= head;
  end

  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
      word_valid_o <= 1'b0;
    else
      word_valid_o <= pop && !flush;
  end

endmodule

// File: hdl/dphy_32b_map.sv
`include "dphy_rx_config.svh"

module dphy_32b_map (
  input  logic                     byte_clk,
  input  logic                     rst_n_i,
  input  logic                     eop_i,
  input  dphy_rx_pkg::lane_bytes_t word_i,
  input  logic                     word_valid_i,
  output logic [31:0]              data_o,
  output logic                     valid_o
);
  localparam int LANES  = `DPHY_DATA_LANES;
  localparam int WORD_W = 8 * LANES;
  // Last lane word reaches us one cycle after the deskew flush point
  localparam int DRAIN  = 4;

  logic [31:0]          shift_q;
  logic [31+WORD_W:0]   shift_in;
  logic [31:0]          shift_next;
  logic [2:0]           byte_cnt;
  logic                 word_done;
  logic [DRAIN-1:0]     eop_q;

  // New lane word enters at the top, earlier words slide down
  assign shift_in   = {word_i, shift_q};
  assign shift_next = shift_in[31+WORD_W:WORD_W];
  assign word_done  = (byte_cnt == 3'(4 - LANES));

  always_ff @(posedge byte_clk)
  begin
    if (word_valid_i)
      shift_q <= shift_next;
    if (word_valid_i && word_done)
      data_o <= shift_next;
  end

  always_ff @(posedge byte_clk)
  begin
    if (!rst_n_i)
    begin
      byte_cnt <= 3'd0;
      valid_o  <= 1'b0;
      eop_q    <= '0;
    end
    else
    begin
      eop_q   <= {eop_q[DRAIN-2:0], eop_i};
      valid_o <= 1'b0;
      // A partial word at end of packet is dropped
      if (eop_q[DRAIN-1])
        byte_cnt <= 3'd0;
      else if (word_valid_i)
      begin
        if (word_done)
        begin
          byte_cnt <= 3'd0;
          valid_o  <= 1'b1;
        end
        else
          byte_cnt <= byte_cnt + 3'(LANES);
      end
    end
  end

endmodule

// File: hdl/dphy_rx_top.sv
`include "dphy_rx_config.svh"

module dphy_rx_top (
  input  logic                     byte_clk,
  input  logic                     rst_n_i,
  input  dphy_rx_pkg::lane_bytes_t lane_byte_i,
  input  dphy_rx_pkg::lane_mask_t  lp_p_i,
  input  dphy_rx_pkg::lane_mask_t  lp_n_i,
  output logic [31:0]              data_o,
  output logic                     valid_o,
  output logic                     sync_err_o
);
  import dphy_rx_pkg::*;

  lane_bytes_t word;
  logic        word_valid;
  logic        eop;
  logic        reset_align;

  dphy_lane_if lane_if [`DPHY_DATA_LANES] ();

  assign sync_err_o = reset_align;

  dphy_rx_front u_front (
    .byte_clk    ( byte_clk    ),
    .rst_n_i     ( rst_n_i     ),
    .lane_byte_i ( lane_byte_i ),
    .lp_p_i      ( lp_p_i      ),
    .lp_n_i      ( lp_n_i      ),
    .lane_o      ( lane_if     ),
    .eop_o       ( eop         )
  );

  // One sync hunter per lane
  for (genvar i = 0; i < `DPHY_DATA_LANES; i++)
  begin : g_align
    dphy_byte_align u_align (
      .byte_clk      ( byte_clk    ),
      .rst_n_i       ( rst_n_i     ),
      .reset_align_i ( reset_align ),
      .lane_io       ( lane_if[i]  )
    );
  end

  dphy_word_align u_deskew (
    .byte_clk      ( byte_clk    ),
    .rst_n_i       ( rst_n_i     ),
    .eop_i         ( eop         ),
    .lanes_i       ( lane_if     ),
    .word_o        ( word        ),
    .word_valid_o  ( word_valid  ),
    .reset_align_o ( reset_align )
  );

  dphy_32b_map u_map (
    .byte_clk     ( byte_clk   ),
    .rst_n_i      ( rst_n_i    ),
    .eop_i        ( eop        ),
    .word_i       ( word       ),
    .word_valid_i ( word_valid ),
    .data_o       ( data_o     ),
    .valid_o      ( valid_o    )
  );

endmodule

// File: verif/dphy_rx_tb_model.svh
`ifndef DPHY_RX_TB_MODEL_SVH
`define DPHY_RX_TB_MODEL_SVH

// Raw byte tables per lane, filled by build_lane and played by send_packet
localparam int MAX_RAW = 64;

logic [7:0] raw_mem [LANES][MAX_RAW];
int         raw_len [LANES];

// Expected output word k: payload bytes 4k..4k+3, earliest byte lowest
function automatic logic [31:0] ref_word(input byte_q_t payload, input int k);
  logic [31:0] w;
  w = '0;
  for (int b = 0; b < 4; b++)
  begin
    w[8*b +: 8] = payload[4*k + b];
  end
  return w;
endfunction

// Only whole words leave the packer
task automatic expect_packet(input byte_q_t payload);
  for (int k = 0; k < payload.size() / 4; k++)
  begin
    exp_q.push_back(ref_word(payload, k));
  end
endtask

task automatic make_payload(input int len, output byte_q_t pl);
  pl = {};
  for (int n = 0; n < len; n++)
  begin
    pl.push_back(8'($random(seed)));
  end
endtask

// Serial stream of one lane: settle bytes, skew bytes, leader, lane bytes, tail
// The stream is delayed by offset bits and cut into raw bytes, LSB first
task automatic build_lane(input int lane, input byte_q_t payload, input int offset,
                          input int skew, input bit settle_b8, input bit with_sync);
  byte_q_t    bytes;
  logic [7:0] b;
  logic [7:0] r;
  int         src;
  bytes = {};
  for (int i = 0; i < SETTLE + 1 + skew; i++)
  begin
    bytes.push_back((settle_b8 && i == 2) ? `DPHY_SYNC_BYTE : 8'h00);
  end
  bytes.push_back(with_sync ? `DPHY_SYNC_BYTE : 8'h00);
  for (int n = lane; n < payload.size(); n += LANES)
  begin
    bytes.push_back(payload[n]);
  end
  // Tail byte carries the bits pushed out by the offset
  bytes.push_back(8'h00);
  raw_len[lane] = bytes.size();
  for (int k = 0; k < bytes.size(); k++)
  begin
    r = '0;
    for (int j = 0; j < 8; j++)
    begin
      src = 8*k + j - offset;
      if (src >= 0)
      begin
        b    = bytes[src / 8];
        r[j] = b[src % 8];
      end
    end
    raw_mem[lane][k] = r;
  end
endtask

`endif

// File: verif/dphy_rx_tb.sv
`include "dphy_rx_config.svh"

module dphy_rx_tb;
  import dphy_rx_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  localparam int LANES      = `DPHY_DATA_LANES;
  localparam int SETTLE     = `DPHY_SETTLE_CYCLES;
  localparam int IDLE       = 24;
  localparam int WAIT_LIMIT = 400;
  localparam int RUN_LIMIT  = 20000;

  logic        byte_clk;
  logic        rst_n_i;
  lane_bytes_t lane_byte_i;
  lane_mask_t  lp_p_i;
  lane_mask_t  lp_n_i;
  logic [31:0] data_o;
  logic        valid_o;
  logic        sync_err_o;

  int          seed;
  int          errors;
  int          err_at_start;
  int          tests_run;
  int          tests_failed;
  int          valid_cnt;
  int          sync_err_cnt;
  logic [31:0] exp_q [$];
  string       test_name;

  `include "dphy_rx_tb_model.svh"

  dphy_rx_top u_dut (
    .byte_clk    ( byte_clk    ),
    .rst_n_i     ( rst_n_i     ),
    .lane_byte_i ( lane_byte_i ),
    .lp_p_i      ( lp_p_i      ),
    .lp_n_i      ( lp_n_i      ),
    .data_o      ( data_o      ),
    .valid_o     ( valid_o     ),
    .sync_err_o  ( sync_err_o  )
  );

  initial
  begin
    byte_clk = 1'b0;
    forever #20 byte_clk = ~byte_clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Compare every output word against the reference queue
  always @(posedge byte_clk)
  begin
    if (rst_n_i)
    begin
      if (sync_err_o)
        sync_err_cnt++;
      if (valid_o)
      begin
        valid_cnt++;
        if (exp_q.size() == 0)
        begin
          $display("%s: word %h came out with no word expected", test_name, data_o);
          errors++;
        end
        else
          check_value(test_name, exp_q.pop_front(), data_o);
      end
    end
  end

  // All lanes in LP-11 with junk on the byte inputs
  task automatic drive_idle(input int cycles);
    for (int t = 0; t < cycles; t++)
    begin
      @(posedge byte_clk);
      lane_byte_i <= lane_bytes_t'($random(seed));
      lp_p_i      <= '1;
      lp_n_i      <= '1;
    end
  endtask

  task automatic send_packet();
    int last;
    last = 0;
    for (int l = 0; l < LANES; l++)
    begin
      if (raw_len[l] > last)
        last = raw_len[l];
    end
    for (int t = 0; t < last; t++)
    begin
      @(posedge byte_clk);
      for (int l = 0; l < LANES; l++)
      begin
        if (t < raw_len[l])
        begin
          lane_byte_i[l] <= raw_mem[l][t];
          lp_p_i[l]      <= 1'b0;
          lp_n_i[l]      <= 1'b0;
        end
        else
        begin
          lane_byte_i[l] <= 8'($random(seed));
          lp_p_i[l]      <= 1'b1;
          lp_n_i[l]      <= 1'b1;
        end
      end
    end
    drive_idle(IDLE);
  endtask

  // Lane l gets bit offset (off0 + step*l) mod 8
  // A negative missing_lane keeps every leader
  task automatic run_packet(input byte_q_t pl, input int off0, input int step,
                            input int skew_lane, input int skew, input bit settle_b8,
                            input int missing_lane);
    for (int l = 0; l < LANES; l++)
    begin
      build_lane(l, pl, (off0 + step*l) % 8, (l == skew_lane) ? skew : 0, settle_b8,
                 l != missing_lane);
    end
    send_packet();
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = errors;
    valid_cnt    = 0;
    sync_err_cnt = 0;
  endtask

  task automatic finish_test();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT)
    begin
      @(posedge byte_clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%s: timed out with %0d words never received", test_name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    drive_idle(IDLE);
    tests_run++;
    if (errors != err_at_start)
    begin
      tests_failed++;
      $display("test %s: failed", test_name);
    end
    else
      $display("test %s: ok", test_name);
  endtask

  task automatic good_packet(input string name, input int off0, input int step,
                             input int skew_lane, input int skew, input bit settle_b8);
    byte_q_t pl;
    start_test(name);
    make_payload(16, pl);
    expect_packet(pl);
    run_packet(pl, off0, step, skew_lane, skew, settle_b8, -1);
    finish_test();
    check_value({name, " sync_err"}, 32'd0, sync_err_cnt);
  endtask

  initial
  begin
    byte_q_t pl;
    seed         = 32'hdf9d;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n_i     <= 1'b0;
    lane_byte_i <= '0;
    lp_p_i      <= '1;
    lp_n_i      <= '1;
    repeat (5) @(posedge byte_clk);
    rst_n_i <= 1'b1;

    start_test("idle_after_reset");
    drive_idle(30);
    check_value("idle_after_reset valid", 32'd0, valid_cnt);
    check_value("idle_after_reset sync_err", 32'd0, sync_err_cnt);
    finish_test();

    good_packet("offset_zero", 0, 0, 0, 0, 1'b0);
    for (int o = 0; o < 8; o++)
    begin
      good_packet($sformatf("offset_%0d", o), o, 3, 0, 0, 1'b0);
    end
    good_packet("skew_lane1_by1", 2, 1, 1, 1, 1'b0);
    good_packet("skew_lane0_by2", 5, 2, 0, 2, 1'b0);
    good_packet("sync_in_settle", 1, 4, 0, 0, 1'b1);

    // Zero payload so no lane can lock on payload data
    start_test("missing_sync");
    pl = {};
    for (int n = 0; n < 16; n++)
      pl.push_back(8'h00);
    run_packet(pl, 0, 0, 0, 0, 1'b0, 1);
    finish_test();
    check_value("missing_sync pulse", 32'd1, sync_err_cnt);
    check_value("missing_sync valid", 32'd0, valid_cnt);
    good_packet("recover_after_sync_err", 3, 1, 0, 0, 1'b0);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Guard against a stuck run
  initial
  begin
    repeat (RUN_LIMIT) @(posedge byte_clk);
    $display("simulation ran past its cycle limit");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
+incdir+verif
hdl/dphy_rx_pkg.sv
hdl/dphy_lane_if.sv
hdl/dphy_rx_front.sv
hdl/dphy_byte_align.sv
hdl/dphy_word_align.sv
hdl/dphy_32b_map.sv
hdl/dphy_rx_top.sv
verif/dphy_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= dphy_rx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(BUILD_DIR)
